// ==== source/fetch_pkg.sv ====
package fetch_pkg;

	// widths with a meaning of their own
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;

	// next fetch address source
	typedef enum logic [2:0] {
		PC_BOOT = 3'd0,
		PC_JUMP = 3'd1,
		PC_EXC  = 3'd2,
		PC_ERET = 3'd3,
		PC_DRET = 3'd4
	} pc_sel_e;

	// exception vector source
	typedef enum logic [1:0] {
		EXC_PC_EXC     = 2'd0,
		EXC_PC_IRQ     = 2'd1,
		EXC_PC_DBD     = 2'd2,
		EXC_PC_DBG_EXC = 2'd3
	} exc_sel_e;

	// debug module entry points
	localparam addr_t DM_HALT_ADDR = 32'h1a110800;
	localparam addr_t DM_EXC_ADDR  = 32'h1a110808;

	// boot code starts this far into the boot page
	localparam logic [7:0] BOOT_OFFSET = 8'h80;

	// bus requests in flight at most
	localparam int unsigned MAX_OUTSTANDING = 2;

	// word entries in the fetch fifo
	// enough for one full word plus every response still in flight
	localparam int unsigned FIFO_DEPTH = 3;

endpackage

// ==== source/rvc_pkg.sv ====
package rvc_pkg;

	// major opcodes of the 32-bit encodings produced by the expander
	localparam logic [6:0] OPC_OP     = 7'h33;
	localparam logic [6:0] OPC_OP_IMM = 7'h13;
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	localparam logic [6:0] OPC_STORE  = 7'h23;
	localparam logic [6:0] OPC_LUI    = 7'h37;
	localparam logic [6:0] OPC_JAL    = 7'h6f;
	localparam logic [6:0] OPC_JALR   = 7'h67;
	localparam logic [6:0] OPC_BRANCH = 7'h63;

	// compressed quadrants in bits 1:0
	// 2'b11 is a full length instruction
	localparam logic [1:0] QUAD_0 = 2'b00;
	localparam logic [1:0] QUAD_1 = 2'b01;
	localparam logic [1:0] QUAD_2 = 2'b10;

endpackage

// ==== source/fetch_addr_mux.sv ====
`timescale 1ns/1ps

module fetch_addr_mux import fetch_pkg::*; (
	input  pc_sel_e    pc_mux_i,
	input  exc_sel_e   exc_pc_mux_i,
	input  logic [6:0] exc_cause_i,
	input  addr_t      boot_addr_i,
	input  addr_t      branch_target_ex_i,
	input  addr_t      csr_mepc_i,
	input  addr_t      csr_depc_i,
	input  addr_t      csr_mtvec_i,
	input  logic       pc_set_i,
	output addr_t      fetch_addr_o,
	output logic       csr_mtvec_init_o
);
	logic [4:0] irq_vec;
	addr_t      exc_pc;
	addr_t      next_addr;

	// vector table index
	// nmi always lands in the last slot
	always_comb begin
		irq_vec = exc_cause_i[4:0];
		if (exc_cause_i[6]) begin
			irq_vec = 5'd31;
		end
	end

	// trap target
	always_comb begin
		case (exc_pc_mux_i)
			EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:8], 8'h00};
			// one word per vector
			EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_vec, 2'b00};
			EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
			EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
			default:        exc_pc = {csr_mtvec_i[31:8], 8'h00};
		endcase
	end

	always_comb begin
		case (pc_mux_i)
			PC_BOOT: next_addr = {boot_addr_i[31:8], BOOT_OFFSET};
			PC_JUMP: next_addr = branch_target_ex_i;
			PC_EXC:  next_addr = exc_pc;
			PC_ERET: next_addr = csr_mepc_i;
			PC_DRET: next_addr = csr_depc_i;
			default: next_addr = {boot_addr_i[31:8], BOOT_OFFSET};
		endcase
	end

	// halfword aligned at least
	assign fetch_addr_o = {next_addr[31:1], 1'b0};

	// mtvec takes its reset value on the boot jump
	assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== source/prefetch_buffer.sv ====
`timescale 1ns/1ps

module prefetch_buffer import fetch_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_ni,
	input  logic  req_i,
	input  logic  branch_i,
	input  addr_t branch_addr_i,
	input  logic  fifo_ready_i,
	input  logic  instr_gnt_i,
	input  logic  instr_rvalid_i,
	input  word_t instr_rdata_i,
	input  logic  instr_bus_err_i,
	output logic  instr_req_o,
	output addr_t instr_addr_o,
	output logic  fifo_clear_o,
	output logic  fifo_valid_o,
	output word_t fifo_rdata_o,
	output logic  fifo_err_o,
	output logic  busy_o
);
	logic [1:0]                 cnt_q;
	logic [1:0]                 cnt_d;
	logic [MAX_OUTSTANDING-1:0] discard_q;
	logic [MAX_OUTSTANDING-1:0] discard_d;
	logic                       started_q;
	logic                       pend_q;
	logic                       pend_discard_q;
	addr_t                      pend_addr_q;
	addr_t                      fetch_addr_q;
	addr_t                      branch_word;
	logic                       start;
	logic                       gnt;
	logic                       gnt_discard;

	assign branch_word = {branch_addr_i[31:2], 2'b00};

	// new request only with a free slot and fifo room
	// fifo fill level is irrelevant on a branch since it flushes
	// nothing goes out before the first redirect
	assign start = req_i & ~pend_q & (started_q | branch_i) &
		(cnt_q < MAX_OUTSTANDING) & (fifo_ready_i | branch_i);

	// an ungranted request keeps req and addr until gnt
	assign instr_req_o  = pend_q | start;
	assign instr_addr_o = pend_q ? pend_addr_q : (branch_i ? branch_word : fetch_addr_q);
	assign gnt          = instr_req_o & instr_gnt_i;

	// the held request is stale once a branch has passed it
	assign gnt_discard = pend_q & (pend_discard_q | branch_i);

	// in flight tracking
	// slot 0 is the oldest response
	always_comb begin
		discard_d = discard_q;
		cnt_d     = cnt_q;
		if (branch_i) begin
			discard_d = '1;
		end
		if (instr_rvalid_i) begin
			discard_d = {1'b0, discard_d[MAX_OUTSTANDING-1:1]};
			cnt_d     = cnt_d - 2'd1;
		end
		if (gnt) begin
			discard_d[cnt_d[0]] = gnt_discard;
			cnt_d               = cnt_d + 2'd1;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			started_q      <= 1'b0;
			pend_q         <= 1'b0;
			pend_discard_q <= 1'b0;
			cnt_q          <= 2'd0;
			discard_q      <= '0;
		end else begin
			if (branch_i) begin
				started_q <= 1'b1;
			end
			pend_q         <= instr_req_o & ~instr_gnt_i;
			pend_discard_q <= pend_q & ~instr_gnt_i & (pend_discard_q | branch_i);
			cnt_q          <= cnt_d;
			discard_q      <= discard_d;
		end
	end

	// next word address
	// a branch behind a held request is issued after it
	always_ff @(posedge clk_i) begin
		if (start) begin
			pend_addr_q  <= instr_addr_o;
			fetch_addr_q <= instr_addr_o + 32'd4;
		end else if (branch_i) begin
			fetch_addr_q <= branch_word;
		end
	end

	assign fifo_clear_o = branch_i;
	// responses in the branch cycle are old too
	assign fifo_valid_o = instr_rvalid_i & ~discard_q[0] & ~branch_i;
	assign fifo_rdata_o = instr_rdata_i;
	assign fifo_err_o   = instr_bus_err_i;

	assign busy_o = pend_q | (cnt_q != 2'd0);

endmodule

// ==== source/fetch_fifo.sv ====
`timescale 1ns/1ps

module fetch_fifo import fetch_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_ni,
	input  logic  clear_i,
	input  addr_t branch_addr_i,
	input  logic  in_valid_i,
	input  word_t in_rdata_i,
	input  logic  in_err_i,
	input  logic  out_ready_i,
	output logic  ready_o,
	output logic  out_valid_o,
	output addr_t out_addr_o,
	output word_t out_rdata_o,
	output logic  out_err_o,
	output logic  out_err_plus2_o
);
	logic [FIFO_DEPTH-1:0] valid_q;
	logic [FIFO_DEPTH-1:0] valid_d;
	logic [FIFO_DEPTH-1:0] err_q;
	logic [FIFO_DEPTH-1:0] err_d;
	word_t                 rdata_q [FIFO_DEPTH];
	word_t                 rdata_d [FIFO_DEPTH];
	addr_t                 addr_q;
	half_t                 lo_half;
	logic                  unaligned;
	logic                  is_compressed;
	logic                  handshake;
	logic                  pop;
	logic                  written;

	// instruction starts in the upper half of the head word
	assign unaligned     = addr_q[1];
	assign lo_half       = unaligned ? rdata_q[0][31:16] : rdata_q[0][15:0];
	assign is_compressed = (lo_half[1:0] != 2'b11);

	// upper bits only matter for a full length instruction
	assign out_rdata_o = unaligned ? {rdata_q[1][15:0], rdata_q[0][31:16]} : rdata_q[0];
	assign out_addr_o  = addr_q;

	always_comb begin
		if (unaligned & ~is_compressed) begin
			// spans two words
			// a faulting first word is enough to report
			out_valid_o     = valid_q[1] | (valid_q[0] & err_q[0]);
			out_err_o       = err_q[0] | err_q[1];
			out_err_plus2_o = ~err_q[0] & err_q[1];
		end else begin
			out_valid_o     = valid_q[0];
			out_err_o       = err_q[0];
			out_err_plus2_o = 1'b0;
		end
	end

	assign handshake = out_valid_o & out_ready_i;
	// head word done unless an aligned compressed leaves its upper half
	assign pop = handshake & (unaligned | ~is_compressed);

	// room for every response that may still arrive
	assign ready_o = ~valid_q[FIFO_DEPTH - MAX_OUTSTANDING];

	always_comb begin
		valid_d = valid_q;
		err_d   = err_q;
		rdata_d = rdata_q;
		written = 1'b0;
		if (pop) begin
			for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
				valid_d[i] = valid_q[i+1];
				err_d[i]   = err_q[i+1];
				rdata_d[i] = rdata_q[i+1];
			end
			valid_d[FIFO_DEPTH-1] = 1'b0;
		end
		// lowest free slot after the pop
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			if (in_valid_i & ~valid_d[i] & ~written) begin
				valid_d[i] = 1'b1;
				err_d[i]   = in_err_i;
				rdata_d[i] = in_rdata_i;
				written    = 1'b1;
			end
		end
		if (clear_i) begin
			valid_d = '0;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_d;
		end
	end

	always_ff @(posedge clk_i) begin
		err_q   <= err_d;
		rdata_q <= rdata_d;
	end

	// instruction pc
	// may start mid word after a branch
	always_ff @(posedge clk_i) begin
		if (clear_i) begin
			addr_q <= branch_addr_i;
		end else if (handshake) begin
			addr_q <= addr_q + (is_compressed ? 32'd2 : 32'd4);
		end
	end

endmodule

// ==== source/compressed_decoder.sv ====
`timescale 1ns/1ps

module compressed_decoder import fetch_pkg::*, rvc_pkg::*; (
	input  word_t instr_i,
	output word_t instr_o,
	output logic  is_compressed_o,
	output logic  illegal_instr_o
);

	always_comb begin
		instr_o         = instr_i;
		illegal_instr_o = 1'b0;

		case (instr_i[1:0])
			QUAD_0: begin
				case (instr_i[15:13])
					// c.addi4spn -> addi rd', x2, nzuimm
					3'b000: begin
						instr_o = {2'b00, instr_i[10:7], instr_i[12:11], instr_i[5],
							instr_i[6], 2'b00, 5'h02, 3'b000, 2'b01, instr_i[4:2], OPC_OP_IMM};
						// zero immediate covers the all zero halfword
						illegal_instr_o = (instr_i[12:5] == 8'h00);
					end
					// c.lw -> lw rd', imm(rs1')
					3'b010: begin
						instr_o = {5'b00000, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
							2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], OPC_LOAD};
					end
					// c.sw -> sw rs2', imm(rs1')
					3'b110: begin
						instr_o = {5'b00000, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
							2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6], 2'b00,
							OPC_STORE};
					end
					default: illegal_instr_o = 1'b1;
				endcase
			end

			QUAD_1: begin
				case (instr_i[15:13])
					// c.addi and c.nop
					3'b000: begin
						instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
							3'b000, instr_i[11:7], OPC_OP_IMM};
					end
					// c.li -> addi rd, x0, imm
					3'b010: begin
						instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b00000,
							3'b000, instr_i[11:7], OPC_OP_IMM};
					end
					// c.lui
					// rd x2 would be c.addi16sp which is not expanded
					3'b011: begin
						instr_o = {{15{instr_i[12]}}, instr_i[6:2], instr_i[11:7], OPC_LUI};
						illegal_instr_o = (instr_i[11:7] == 5'h02) |
							({instr_i[12], instr_i[6:2]} == 6'h00);
					end
					// c.j -> jal x0
					3'b101: begin
						instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
							instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
							{9{instr_i[12]}}, 5'b00000, OPC_JAL};
					end
					// c.beqz and c.bnez
					// funct3 taken from bit 13
					3'b110, 3'b111: begin
						instr_o = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'b00000,
							2'b01, instr_i[9:7], 2'b00, instr_i[13], instr_i[11:10],
							instr_i[4:3], instr_i[12], OPC_BRANCH};
					end
					default: illegal_instr_o = 1'b1;
				endcase
			end

			QUAD_2: begin
				case (instr_i[15:13])
					// c.slli
					// shamt[5] set is not rv32
					3'b000: begin
						instr_o = {7'b0000000, instr_i[6:2], instr_i[11:7], 3'b001,
							instr_i[11:7], OPC_OP_IMM};
						illegal_instr_o = instr_i[12];
					end
					// c.lwsp -> lw rd, imm(x2)
					3'b010: begin
						instr_o = {4'b0000, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00,
							5'h02, 3'b010, instr_i[11:7], OPC_LOAD};
						illegal_instr_o = (instr_i[11:7] == 5'h00);
					end
					3'b100: begin
						if (instr_i[6:2] != 5'h00) begin
							// c.mv adds to x0 and c.add adds to rd
							instr_o = {7'b0000000, instr_i[6:2],
								instr_i[12] ? instr_i[11:7] : 5'b00000, 3'b000,
								instr_i[11:7], OPC_OP};
						end else begin
							// c.jr -> jalr x0, 0(rs1)
							instr_o = {12'h000, instr_i[11:7], 3'b000, 5'b00000, OPC_JALR};
							// c.jalr and c.ebreak are outside the subset
							illegal_instr_o = instr_i[12] | (instr_i[11:7] == 5'h00);
						end
					end
					// c.swsp -> sw rs2, imm(x2)
					3'b110: begin
						instr_o = {4'b0000, instr_i[8:7], instr_i[12], instr_i[6:2], 5'h02,
							3'b010, instr_i[11:9], 2'b00, OPC_STORE};
					end
					default: illegal_instr_o = 1'b1;
				endcase
			end

			// full length passes unchanged
			default: ;
		endcase
	end

	assign is_compressed_o = (instr_i[1:0] != 2'b11);

endmodule

// ==== source/if_stage.sv ====
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  addr_t      boot_addr_i,
	input  logic       req_i,
	output logic       instr_req_o,
	output addr_t      instr_addr_o,
	input  logic       instr_gnt_i,
	input  logic       instr_rvalid_i,
	input  word_t      instr_rdata_i,
	input  logic       instr_bus_err_i,
	input  logic       pc_set_i,
	input  pc_sel_e    pc_mux_i,
	input  exc_sel_e   exc_pc_mux_i,
	input  logic [6:0] exc_cause_i,
	input  addr_t      branch_target_ex_i,
	input  addr_t      csr_mepc_i,
	input  addr_t      csr_depc_i,
	input  addr_t      csr_mtvec_i,
	input  logic       instr_valid_clear_i,
	input  logic       id_in_ready_i,
	output logic       instr_valid_id_o,
	output logic       instr_new_id_o,
	output word_t      instr_rdata_id_o,
	output half_t      instr_rdata_c_id_o,
	output logic       instr_is_compressed_id_o,
	output logic       illegal_c_insn_id_o,
	output logic       instr_fetch_err_o,
	output logic       instr_fetch_err_plus2_o,
	output addr_t      pc_if_o,
	output addr_t      pc_id_o,
	output logic       csr_mtvec_init_o,
	output logic       if_busy_o
);
	addr_t branch_addr;
	logic  fifo_clear;
	logic  fifo_valid;
	word_t fifo_rdata;
	logic  fifo_err;
	logic  fifo_ready;
	logic  out_valid;
	addr_t out_addr;
	word_t out_rdata;
	logic  out_err;
	logic  out_err_plus2;
	word_t instr_decompressed;
	logic  instr_is_compressed;
	logic  illegal_c_insn;
	logic  if_id_we;
	logic  instr_valid_id_d;

	fetch_addr_mux u_fetch_addr_mux (
		.pc_mux_i           (pc_mux_i),
		.exc_pc_mux_i       (exc_pc_mux_i),
		.exc_cause_i        (exc_cause_i),
		.boot_addr_i        (boot_addr_i),
		.branch_target_ex_i (branch_target_ex_i),
		.csr_mepc_i         (csr_mepc_i),
		.csr_depc_i         (csr_depc_i),
		.csr_mtvec_i        (csr_mtvec_i),
		.pc_set_i           (pc_set_i),
		.fetch_addr_o       (branch_addr),
		.csr_mtvec_init_o   (csr_mtvec_init_o)
	);

	// every pc_set is a redirect of the fetch stream
	prefetch_buffer u_prefetch_buffer (
		.clk_i           (clk_i),
		.rst_ni          (rst_ni),
		.req_i           (req_i),
		.branch_i        (pc_set_i),
		.branch_addr_i   (branch_addr),
		.fifo_ready_i    (fifo_ready),
		.instr_gnt_i     (instr_gnt_i),
		.instr_rvalid_i  (instr_rvalid_i),
		.instr_rdata_i   (instr_rdata_i),
		.instr_bus_err_i (instr_bus_err_i),
		.instr_req_o     (instr_req_o),
		.instr_addr_o    (instr_addr_o),
		.fifo_clear_o    (fifo_clear),
		.fifo_valid_o    (fifo_valid),
		.fifo_rdata_o    (fifo_rdata),
		.fifo_err_o      (fifo_err),
		.busy_o          (if_busy_o)
	);

	fetch_fifo u_fetch_fifo (
		.clk_i           (clk_i),
		.rst_ni          (rst_ni),
		.clear_i         (fifo_clear),
		.branch_addr_i   (branch_addr),
		.in_valid_i      (fifo_valid),
		.in_rdata_i      (fifo_rdata),
		.in_err_i        (fifo_err),
		.out_ready_i     (id_in_ready_i),
		.ready_o         (fifo_ready),
		.out_valid_o     (out_valid),
		.out_addr_o      (out_addr),
		.out_rdata_o     (out_rdata),
		.out_err_o       (out_err),
		.out_err_plus2_o (out_err_plus2)
	);

	compressed_decoder u_compressed_decoder (
		.instr_i         (out_rdata),
		.instr_o         (instr_decompressed),
		.is_compressed_o (instr_is_compressed),
		.illegal_instr_o (illegal_c_insn)
	);

	assign pc_if_o = out_addr;

	// handshake with decode
	assign if_id_we = out_valid & id_in_ready_i;

	// an instruction loaded under a redirect is dropped
	// otherwise valid holds until decode clears it
	assign instr_valid_id_d = (if_id_we & ~pc_set_i) |
		(instr_valid_id_o & ~instr_valid_clear_i);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			instr_valid_id_o <= 1'b0;
			instr_new_id_o   <= 1'b0;
		end else begin
			instr_valid_id_o <= instr_valid_id_d;
			instr_new_id_o   <= if_id_we;
		end
	end

	// if/id data
	// a failed fetch carries junk so the expander verdict is masked
	always_ff @(posedge clk_i) begin
		if (if_id_we) begin
			instr_rdata_id_o         <= instr_decompressed;
			instr_rdata_c_id_o       <= out_rdata[15:0];
			instr_is_compressed_id_o <= instr_is_compressed;
			illegal_c_insn_id_o      <= illegal_c_insn & ~out_err;
			instr_fetch_err_o        <= out_err;
			instr_fetch_err_plus2_o  <= out_err_plus2;
			pc_id_o                  <= out_addr;
		end
	end

endmodule

// ==== testbench/instr_mem_model.sv ====
`timescale 1ns/1ps

module instr_mem_model import fetch_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_ni,
	input  logic  req_i,
	input  addr_t addr_i,
	output logic  gnt_o,
	output logic  rvalid_o,
	output word_t rdata_o,
	output logic  err_o
);
	// sparse image and error marks, filled by the testbench
	word_t       mem [addr_t];
	bit          err_word [addr_t];
	// accepted requests in order, with cycles left until the response
	addr_t       resp_addr [$];
	int unsigned resp_wait [$];
	int unsigned gnt_wait;
	logic        gnt_allow;
	integer      seed;
	addr_t       head;

	initial begin
		seed      = 32'ha5b3;
		gnt_wait  = 0;
		gnt_allow = 1'b0;
		rvalid_o  = 1'b0;
		rdata_o   = '0;
		err_o     = 1'b0;
	end

	// grant follows req in the same cycle once the wait has run out
	assign gnt_o = req_i & gnt_allow;

	// unwritten words get a pattern built from the whole address
	function automatic word_t read_word(input addr_t wa);
		if (mem.exists(wa)) begin
			return mem[wa];
		end
		return {wa[15:0], wa[31:16]} ^ 32'hc3a55a3c;
	endfunction

	// bookkeeping on the rising edge, with pre-edge values
	always @(posedge clk_i) begin
		if (!rst_ni) begin
			resp_addr.delete();
			resp_wait.delete();
			gnt_wait = 0;
		end else begin
			if (rvalid_o) begin
				void'(resp_addr.pop_front());
				void'(resp_wait.pop_front());
			end
			if (resp_wait.size() > 0 && resp_wait[0] > 0) begin
				resp_wait[0] = resp_wait[0] - 1;
			end
			if (req_i && gnt_o) begin
				resp_addr.push_back(addr_i);
				resp_wait.push_back(1 + ($unsigned($random(seed)) % 3));
				gnt_wait = $unsigned($random(seed)) % 3;
			end else if (req_i && gnt_wait > 0) begin
				gnt_wait = gnt_wait - 1;
			end
		end
	end

	// bus outputs change on the falling edge
	always @(negedge clk_i) begin
		gnt_allow = rst_ni && (gnt_wait == 0);
		if (rst_ni && resp_wait.size() > 0 && resp_wait[0] == 0) begin
			head     = resp_addr[0];
			rvalid_o = 1'b1;
			rdata_o  = read_word(head);
			err_o    = err_word.exists(head);
		end else begin
			rvalid_o = 1'b0;
			err_o    = 1'b0;
		end
	end

endmodule

// ==== testbench/tb_if_stage.sv ====
`timescale 1ns/1ps

module tb_if_stage import fetch_pkg::*; ();
	localparam int TIMEOUT = 200;

	logic       clk_i;
	logic       rst_ni;
	addr_t      boot_addr_i;
	logic       req_i;
	logic       instr_req_o;
	addr_t      instr_addr_o;
	logic       instr_gnt_i;
	logic       instr_rvalid_i;
	word_t      instr_rdata_i;
	logic       instr_bus_err_i;
	logic       pc_set_i;
	pc_sel_e    pc_mux_i;
	exc_sel_e   exc_pc_mux_i;
	logic [6:0] exc_cause_i;
	addr_t      branch_target_ex_i;
	addr_t      csr_mepc_i;
	addr_t      csr_depc_i;
	addr_t      csr_mtvec_i;
	logic       instr_valid_clear_i;
	logic       id_in_ready_i;
	logic       instr_valid_id_o;
	logic       instr_new_id_o;
	word_t      instr_rdata_id_o;
	half_t      instr_rdata_c_id_o;
	logic       instr_is_compressed_id_o;
	logic       illegal_c_insn_id_o;
	logic       instr_fetch_err_o;
	logic       instr_fetch_err_plus2_o;
	addr_t      pc_if_o;
	addr_t      pc_id_o;
	logic       csr_mtvec_init_o;
	logic       if_busy_o;

	// own copy of the image for expected values
	word_t  img [addr_t];
	bit     errw [addr_t];
	integer seed;
	// last redirect and last instruction seen by decode
	logic   granted;
	addr_t  grant_addr;
	logic   init_seen;
	addr_t  rx_pc;
	addr_t  rx_pc_if;
	word_t  rx_rdata;
	half_t  rx_c;
	logic   rx_is_c;
	logic   rx_ill;
	logic   rx_err;
	logic   rx_plus2;

	if_stage if_stage_i (.*);

	instr_mem_model mem_model (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.req_i    (instr_req_o),
		.addr_i   (instr_addr_o),
		.gnt_o    (instr_gnt_i),
		.rvalid_o (instr_rvalid_i),
		.rdata_o  (instr_rdata_i),
		.err_o    (instr_bus_err_i)
	);

	initial clk_i = 1'b0;
	always #5 clk_i = ~clk_i;

	task automatic check_value(input string test, input string what, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s: %s expected %h actual %h", test, what, exp, act);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	function automatic half_t half_at(input addr_t a);
		word_t w;
		w = img.exists({a[31:2], 2'b00}) ? img[{a[31:2], 2'b00}] : '0;
		return a[1] ? w[31:16] : w[15:0];
	endfunction

	function automatic logic err_at(input addr_t a);
		return errw.exists({a[31:2], 2'b00});
	endfunction

	// stop fetching and let every bus transfer finish
	task automatic quiesce();
		int cycles;
		cycles = 0;
		@(negedge clk_i);
		req_i         = 1'b0;
		id_in_ready_i = 1'b1;
		do begin
			@(posedge clk_i);
			cycles++;
			if (cycles > TIMEOUT) begin
				report_timeout("the fetch stage to go idle");
			end
		end while (if_busy_o);
		@(negedge clk_i);
	endtask

	// one cycle of pc_set, fetch enabled from the same cycle
	task automatic redirect(input pc_sel_e sel, input exc_sel_e exc, input logic [6:0] cause,
			input addr_t tvec, input addr_t target);
		@(negedge clk_i);
		pc_mux_i           = sel;
		exc_pc_mux_i       = exc;
		exc_cause_i        = cause;
		csr_mtvec_i        = tvec;
		branch_target_ex_i = target;
		pc_set_i           = 1'b1;
		req_i              = 1'b1;
		@(posedge clk_i);
		init_seen  = csr_mtvec_init_o;
		granted    = instr_req_o && instr_gnt_i;
		grant_addr = instr_addr_o;
		@(negedge clk_i);
		pc_set_i = 1'b0;
	endtask

	task automatic wait_grant();
		int cycles;
		cycles = 0;
		while (!granted) begin
			@(posedge clk_i);
			if (instr_req_o && instr_gnt_i) begin
				granted    = 1'b1;
				grant_addr = instr_addr_o;
			end
			cycles++;
			if (cycles > TIMEOUT) begin
				report_timeout("the first request after a redirect to be granted");
			end
		end
		@(negedge clk_i);
	endtask

	// next instruction that decode accepts as new and valid
	// pc_if then already points past it
	task automatic receive_instr(input logic bp);
		int   cycles;
		logic got;
		cycles = 0;
		got    = 1'b0;
		while (!got) begin
			@(posedge clk_i);
			if (instr_new_id_o && instr_valid_id_o) begin
				got      = 1'b1;
				rx_pc    = pc_id_o;
				rx_pc_if = pc_if_o;
				rx_rdata = instr_rdata_id_o;
				rx_c     = instr_rdata_c_id_o;
				rx_is_c  = instr_is_compressed_id_o;
				rx_ill   = illegal_c_insn_id_o;
				rx_err   = instr_fetch_err_o;
				rx_plus2 = instr_fetch_err_plus2_o;
			end
			@(negedge clk_i);
			// decode stalls on about one cycle in four
			id_in_ready_i = bp ? (($random(seed) & 3) != 0) : 1'b1;
			cycles++;
			if (cycles > TIMEOUT) begin
				report_timeout("an instruction in the IF/ID register");
			end
		end
	endtask

	// length, halves and error flags follow from the image at pc
	task automatic check_instr(input string test, input addr_t pc);
		half_t lo;
		half_t hi;
		logic  comp;
		logic  first_err;
		logic  second_err;
		addr_t next_pc;
		lo         = half_at(pc);
		hi         = half_at(pc + 32'd2);
		comp       = (lo[1:0] != 2'b11);
		first_err  = err_at(pc);
		second_err = !comp && pc[1] && err_at(pc + 32'd2);
		next_pc    = pc + (comp ? 32'd2 : 32'd4);
		check_value(test, "pc_id", pc, rx_pc);
		check_value(test, "pc_if", next_pc, rx_pc_if);
		check_value(test, "is_compressed", {31'd0, comp}, {31'd0, rx_is_c});
		check_value(test, "rdata_c", {16'd0, lo}, {16'd0, rx_c});
		check_value(test, "fetch_err", {31'd0, first_err | second_err}, {31'd0, rx_err});
		check_value(test, "fetch_err_plus2", {31'd0, !first_err && second_err},
			{31'd0, rx_plus2});
		if (!comp && !first_err && !second_err) begin
			check_value(test, "rdata_id", {hi, lo}, rx_rdata);
		end
	endtask

	initial begin
		int     fd;
		int     tests_run;
		string  line;
		string  kind;
		string  name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		addr_t  pc;

		seed                = 32'ha5b3;
		tests_run           = 0;
		rst_ni              = 1'b0;
		boot_addr_i         = '0;
		req_i               = 1'b0;
		pc_set_i            = 1'b0;
		pc_mux_i            = PC_BOOT;
		exc_pc_mux_i        = EXC_PC_EXC;
		exc_cause_i         = '0;
		branch_target_ex_i  = '0;
		csr_mepc_i          = '0;
		csr_depc_i          = '0;
		csr_mtvec_i         = '0;
		// decode consumes each instruction in one cycle
		instr_valid_clear_i = 1'b1;
		id_in_ready_i       = 1'b1;
		repeat (4) @(negedge clk_i);
		rst_ni = 1'b1;

		fd = $fopen("testbench/if_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/if_tests.txt");
			$display("** FAIL **");
			$fatal(1);
		end
		while ($fgets(line, fd) != 0) begin
			// skip comments and blank lines
			if (line.len() > 2 && line.getc(0) != "#") begin
				a = '0;
				b = '0;
				c = '0;
				d = '0;
				void'($sscanf(line, "%s %s %h %h %h %h", kind, name, a, b, c, d));
				if (kind == "mem") begin
					img[a]           = b;
					mem_model.mem[a] = b;
				end else if (kind == "err") begin
					errw[a]               = 1'b1;
					mem_model.err_word[a] = 1'b1;
				end else if (kind == "boot") begin
					quiesce();
					boot_addr_i = a;
					redirect(PC_BOOT, EXC_PC_EXC, 7'd0, csr_mtvec_i, '0);
					wait_grant();
					check_value(name, "first address", {b[31:2], 2'b00}, grant_addr);
					check_value(name, "mtvec_init", 32'd1, {31'd0, init_seen});
					tests_run++;
				end else if (kind == "vec") begin
					quiesce();
					redirect(PC_EXC, exc_sel_e'(a[1:0]), b[6:0], c, '0);
					wait_grant();
					check_value(name, "first address", {d[31:2], 2'b00}, grant_addr);
					check_value(name, "mtvec_init", 32'd0, {31'd0, init_seen});
					tests_run++;
				end else if (kind == "run") begin
					quiesce();
					redirect(PC_JUMP, EXC_PC_EXC, 7'd0, csr_mtvec_i, a);
					pc = a;
					for (int i = 0; i < int'(b); i++) begin
						receive_instr(c[0]);
						check_instr(name, pc);
						pc = pc + ((half_at(pc) & 16'h3) != 16'h3 ? 32'd2 : 32'd4);
					end
					// jump mid stream, nothing stale may follow
					if (d != 0) begin
						redirect(PC_JUMP, EXC_PC_EXC, 7'd0, csr_mtvec_i, d);
						receive_instr(1'b0);
						check_instr(name, d);
					end
					tests_run++;
				end else if (kind == "decode") begin
					quiesce();
					redirect(PC_JUMP, EXC_PC_EXC, 7'd0, csr_mtvec_i, a);
					receive_instr(1'b0);
					check_value(name, "pc_id", a, rx_pc);
					check_value(name, "illegal", {31'd0, c[0]}, {31'd0, rx_ill});
					if (!c[0]) begin
						check_value(name, "expansion", b, rx_rdata);
					end
					tests_run++;
				end
			end
		end
		$fclose(fd);

		if (tests_run == 0) begin
			$display("no test records were found");
			$display("** FAIL **");
			$fatal(1);
		end else begin
			$display("%0d tests done", tests_run);
			$display("** PASS **");
			$finish;
		end
	end

endmodule

// ==== testbench/if_tests.txt ====
# kind name a b c d, all hex; mem: addr word, err: addr, boot: boot_addr expected
# vec: exc_sel cause mtvec expected, run: start count backpressure jump, decode: addr exp illegal
mem s0 00000100 410d0085 0 0
mem s1 00000104 00500193 0 0
mem s2 00000108 82b38212 0 0
mem s3 0000010c 00010020 0 0
mem s4 00000110 00012303 0 0
mem e0 00000200 00500193 0 0
mem e1 00000204 82b30001 0 0
mem e2 00000208 00010020 0 0
mem d0 00000300 00010040 0 0
mem d1 00000304 00014144 0 0
mem d2 00000308 0001908a 0 0
mem d3 0000030c 0001c416 0 0
mem d4 00000310 0001c001 0 0
mem d5 00000314 00010000 0 0
mem d6 00000318 00016105 0 0
err e0 00000200 0 0 0
err e2 00000208 0 0 0
boot boot_page 1a000000 1a000080 0 0
boot boot_low 000012ab 00001280 0 0
vec vec_direct 0 0 00000401 00000400
vec vec_irq7 1 07 00000400 0000041c
vec vec_nmi 1 60 00000400 0000047c
vec vec_dbg_halt 2 0 0 1a110800
vec vec_dbg_exc 3 0 0 1a110808
run seq_stream 00000100 7 0 0
run seq_backpressure 00000100 7 1 0
run bus_error 00000200 4 0 0
run jump_redirect 00000100 3 0 0000010a
decode c_addi4spn 00000300 00410413 0 0
decode c_lw 00000304 00452483 0 0
decode c_add 00000308 002080b3 0 0
decode c_swsp 0000030c 00512423 0 0
decode c_beqz 00000310 00040063 0 0
decode zero_half 00000314 0 1 0
decode c_lui_sp 00000318 0 1 0

// ==== verilog.f ====
source/fetch_pkg.sv
source/rvc_pkg.sv
source/fetch_addr_mux.sv
source/prefetch_buffer.sv
source/fetch_fifo.sv
source/compressed_decoder.sv
source/if_stage.sv
testbench/instr_mem_model.sv
testbench/tb_if_stage.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_if_stage

$(SIM): verilog.f $(shell cat verilog.f)
	verilator --binary --timing -Wno-fatal --top-module tb_if_stage -f verilog.f -o Vtb_if_stage

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
